//--- rtl/cpu_pkg.sv
// CPU shared types
`default_nettype none

package cpu_pkg;

    // ----------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_BEQ  = 2'd1,
        BR_BNE  = 2'd2
    } branch_op_e;

    // ----------------------------------------------------------
    // Pipeline and port structs
    // ----------------------------------------------------------

    // All-zero value is a bubble
    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       alu_src_imm;  // Second ALU operand from immediate
        alu_op_e    alu_op;
        branch_op_e branch_op;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dmem_req_t;

    // addi x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

//--- rtl/cpu_decoder.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module cpu_decoder (
    input  logic [31:0]    instr,
    output cpu_pkg::ctrl_t ctrl,
    output logic [4:0]     rs1,
    output logic [4:0]     rs2,
    output logic [4:0]     rd,
    output logic [31:0]    imm
);
    import cpu_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // Shared funct3 table of OP and OP_IMM
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_decode = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_decode = ALU_SLL;
            3'b010:  alu_decode = ALU_SLT;
            3'b011:  alu_decode = ALU_SLTU;
            3'b100:  alu_decode = ALU_XOR;
            3'b101:  alu_decode = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_decode = ALU_OR;
            default: alu_decode = ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;                // Bubble unless recognised
        rs1  = 5'd0;
        rs2  = 5'd0;
        rd   = 5'd0;
        imm  = 32'd0;
        case (opcode)
            OPC_OP: begin
                // Only SUB and SRA take the alternate funct7
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = alu_decode(funct3, funct7[5]);
                    rs1            = instr[19:15];
                    rs2            = instr[24:20];
                    rd             = instr[11:7];
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    // Immediate shifts
                    if (funct7 == 7'b0000000 || (funct3 == 3'b101 && funct7 == 7'b0100000)) begin
                        ctrl.reg_write   = 1'b1;
                        ctrl.alu_src_imm = 1'b1;
                        ctrl.alu_op      = alu_decode(funct3, funct7[5]);
                        rs1              = instr[19:15];
                        rd               = instr[11:7];
                        imm              = {27'd0, instr[24:20]};  // shamt
                    end
                end else begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = alu_decode(funct3, 1'b0);
                    rs1              = instr[19:15];
                    rd               = instr[11:7];
                    imm              = i_imm;
                end
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin  // LW only
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    rs1              = instr[19:15];
                    rd               = instr[11:7];
                    imm              = i_imm;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin  // SW only
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    rs1              = instr[19:15];
                    rs2              = instr[24:20];
                    imm              = s_imm;
                end
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl.alu_op    = ALU_SUB;  // Equality from the zero flag
                    ctrl.branch_op = (funct3 == 3'b000) ? BR_BEQ : BR_BNE;
                    rs1            = instr[19:15];
                    rs2            = instr[24:20];
                    imm            = b_imm;
                end
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/cpu_alu.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  cpu_pkg::alu_op_e op,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    output logic [31:0]      result,
    output logic             zero
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = 32'd0;
        endcase
    end

    // Branch compare flag
    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

//--- rtl/cpu_regfile.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);
    logic [31:0] regs [32];
    logic        wr_en;

    assign wr_en = we && (rd != 5'd0);  // x0 stays zero

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en) begin
            regs[rd] <= wdata;
        end
    end

    // Bypass for the register written this cycle
    assign rdata1 = (wr_en && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (wr_en && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

//--- rtl/cpu_hazard_unit.sv
// RAW hazard detection
`timescale 1ns/1ps
`default_nettype none

module cpu_hazard_unit (
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] ex_rd,
    input  logic       ex_reg_write,
    input  logic [4:0] mem_rd,
    input  logic       mem_reg_write,
    output logic       stall
);
    logic ex_pending;
    logic mem_pending;
    logic ex_hit;
    logic mem_hit;

    // A stage only counts when it will write a real register
    assign ex_pending  = ex_reg_write && (ex_rd != 5'd0);
    assign mem_pending = mem_reg_write && (mem_rd != 5'd0);

    assign ex_hit  = ex_pending && (ex_rd == rs1 || ex_rd == rs2);
    assign mem_hit = mem_pending && (mem_rd == rs1 || mem_rd == rs2);

    // Writeback is covered by the register file bypass
    assign stall = ex_hit || mem_hit;

endmodule

`default_nettype wire

//--- rtl/cpu.sv
// Five-stage RV32I core
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               reset_n,
    output cpu_pkg::imem_req_t imem_req,
    input  logic               imem_ready,
    input  logic [31:0]        imem_rdata,
    output cpu_pkg::dmem_req_t dmem_req,
    input  logic               dmem_ready,
    input  logic [31:0]        dmem_rdata
);
    import cpu_pkg::*;

    // Fetch state
    logic [31:0] pc;
    logic        fetch_en;
    logic        redirect_pending;  // Taken branch waiting for old fetch
    logic [31:0] redirect_pc;

    // IF/ID
    logic [31:0] ifid_instr;
    logic [31:0] ifid_pc;

    // ID/EX
    ctrl_t       idex_ctrl;
    logic [31:0] idex_pc;
    logic [31:0] idex_rs1_data;
    logic [31:0] idex_rs2_data;
    logic [31:0] idex_imm;
    logic [4:0]  idex_rd;

    // EX/MEM
    ctrl_t       exmem_ctrl;
    logic [31:0] exmem_alu;
    logic        exmem_zero;
    logic [31:0] exmem_wdata;
    logic [4:0]  exmem_rd;
    logic [31:0] exmem_target;

    // MEM/WB
    logic        memwb_reg_write;
    logic        memwb_mem_to_reg;
    logic [31:0] memwb_alu;
    logic [31:0] memwb_load;
    logic [4:0]  memwb_rd;

    ctrl_t       dec_ctrl;
    logic [4:0]  dec_rs1;
    logic [4:0]  dec_rs2;
    logic [4:0]  dec_rd;
    logic [31:0] dec_imm;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [31:0] wb_data;

    logic        stall;
    logic        freeze;
    logic        fetch_fire;
    logic        branch_taken;

    // ----------------------------------------------------------
    // Pipeline control
    // ----------------------------------------------------------
    assign freeze     = dmem_req.valid && !dmem_ready;  // Data port back-pressure
    assign fetch_fire = imem_req.valid && imem_ready;

    assign branch_taken = (exmem_ctrl.branch_op == BR_BEQ && exmem_zero) ||
                          (exmem_ctrl.branch_op == BR_BNE && !exmem_zero);

    // ----------------------------------------------------------
    // Fetch
    // ----------------------------------------------------------
    always_comb begin
        imem_req.valid = fetch_en && !freeze;
        imem_req.addr  = pc;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc               <= reset_pc;
            fetch_en         <= 1'b0;
            redirect_pending <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (!freeze) begin
                if (branch_taken) begin
                    // Address must stay put until the open request completes
                    if (imem_req.valid && !imem_ready) begin
                        redirect_pending <= 1'b1;
                    end else begin
                        pc <= exmem_target;
                    end
                end else if (fetch_fire) begin
                    if (redirect_pending) begin
                        pc               <= redirect_pc;
                        redirect_pending <= 1'b0;
                    end else if (!stall) begin
                        pc <= pc + 32'd4;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (branch_taken) begin
            redirect_pc <= exmem_target;
        end
    end

    // IF/ID
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ifid_instr <= nop_instr;
        end else if (!freeze) begin
            if (branch_taken) begin
                ifid_instr <= nop_instr;  // Flush
            end else if (!stall) begin
                if (fetch_fire && !redirect_pending) begin
                    ifid_instr <= imem_rdata;
                end else begin
                    ifid_instr <= nop_instr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !stall && fetch_fire) begin
            ifid_pc <= pc;
        end
    end

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    cpu_decoder decoder_i (
        .instr (ifid_instr),
        .ctrl  (dec_ctrl),
        .rs1   (dec_rs1),
        .rs2   (dec_rs2),
        .rd    (dec_rd),
        .imm   (dec_imm)
    );

    cpu_regfile regfile_i (
        .clk     (clk),
        .reset_n (reset_n),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .rd      (memwb_rd),
        .we      (memwb_reg_write),
        .wdata   (wb_data),
        .rdata1  (rf_rdata1),
        .rdata2  (rf_rdata2)
    );

    cpu_hazard_unit hazard_i (
        .rs1           (dec_rs1),
        .rs2           (dec_rs2),
        .ex_rd         (idex_rd),
        .ex_reg_write  (idex_ctrl.reg_write),
        .mem_rd        (exmem_rd),
        .mem_reg_write (exmem_ctrl.reg_write),
        .stall         (stall)
    );

    // ID/EX
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idex_ctrl <= '0;
        end else if (!freeze) begin
            if (branch_taken || stall) begin
                idex_ctrl <= '0;  // Bubble
            end else begin
                idex_ctrl <= dec_ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            idex_pc       <= ifid_pc;
            idex_rs1_data <= rf_rdata1;
            idex_rs2_data <= rf_rdata2;
            idex_imm      <= dec_imm;
            idex_rd       <= dec_rd;
        end
    end

    // ----------------------------------------------------------
    // Execute
    // ----------------------------------------------------------
    assign alu_b = idex_ctrl.alu_src_imm ? idex_imm : idex_rs2_data;

    cpu_alu alu_i (
        .op     (idex_ctrl.alu_op),
        .a      (idex_rs1_data),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // EX/MEM
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exmem_ctrl <= '0;
        end else if (!freeze) begin
            exmem_ctrl <= branch_taken ? '0 : idex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            exmem_alu    <= alu_result;
            exmem_zero   <= alu_zero;
            exmem_wdata  <= idex_rs2_data;
            exmem_rd     <= idex_rd;
            exmem_target <= idex_pc + idex_imm;  // Branch target
        end
    end

    // ----------------------------------------------------------
    // Memory
    // ----------------------------------------------------------
    always_comb begin
        dmem_req.valid = exmem_ctrl.mem_read || exmem_ctrl.mem_write;
        dmem_req.write = exmem_ctrl.mem_write;
        dmem_req.addr  = exmem_alu;
        dmem_req.wdata = exmem_wdata;
    end

    // MEM/WB
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            memwb_reg_write  <= 1'b0;
            memwb_mem_to_reg <= 1'b0;
        end else if (!freeze) begin
            memwb_reg_write  <= exmem_ctrl.reg_write;
            memwb_mem_to_reg <= exmem_ctrl.mem_read;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            memwb_alu  <= exmem_alu;
            memwb_load <= dmem_rdata;
            memwb_rd   <= exmem_rd;
        end
    end

    // ----------------------------------------------------------
    // Writeback
    // ----------------------------------------------------------
    assign wb_data = memwb_mem_to_reg ? memwb_load : memwb_alu;

endmodule

`default_nettype wire

//--- dv/cpu_tb_model.svh
// Program generator and reference model
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// ------------------------------------------------------------
// Random source and encoders
// ------------------------------------------------------------
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Uniform pick in 0 .. n-1
function automatic int rnd(input int n);
    logic [31:0] v;
    v = lcg_next();
    return int'(v[30:16]) % n;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

// Initial data memory contents, keyed on the full byte address
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
endfunction

// Random operand words in the first 48 words of the data region
function automatic logic [11:0] data_offset();
    return 12'(DATA_BASE + 4 * rnd(48));
endfunction

task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
endtask

// ------------------------------------------------------------
// Program generation
// ------------------------------------------------------------
task automatic gen_random_instr();
    int         kind;
    logic [4:0] rd;
    logic [4:0] rd2;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    kind = rnd(10);
    rd   = 5'(1 + rnd(15));
    rd2  = 5'(1 + rnd(15));
    rs1  = 5'(rnd(16));
    rs2  = 5'(rnd(16));
    case (kind)
        0, 1, 2, 3: begin
            f3 = 3'(rnd(8));
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00;
            emit(enc_r(f7, rs2, rs1, f3, rd));
        end
        4, 5: begin
            f3 = 3'(rnd(8));
            if (f3 == 3'd1 || f3 == 3'd5) begin
                f3 = 3'd0;          // Shifts have their own case
            end
            emit(enc_i(12'(rnd(4096)), rs1, f3, rd, 7'h13));
        end
        6: begin
            f3 = (rnd(2) == 1) ? 3'd5 : 3'd1;
            f7 = (f3 == 3'd5 && rnd(2) == 1) ? 7'h20 : 7'h00;
            emit(enc_i({f7, 5'(rnd(32))}, rs1, f3, rd, 7'h13));
        end
        7: begin
            // Load followed directly by a use
            emit(enc_i(data_offset(), 5'd0, 3'b010, rd, 7'h03));
            emit(enc_r(7'h00, rs2, rd, 3'd0, rd2));
            touched[rd2[3:0]] = 1'b1;
        end
        8: begin
            emit(enc_s(data_offset(), rs2, 5'd0));
        end
        default: begin
            // Dependent pair back to back
            emit(enc_i(12'(rnd(4096)), rs1, 3'd0, rd, 7'h13));
            emit(enc_r(7'h20, rd, rs2, 3'd0, rd2));
            touched[rd2[3:0]] = 1'b1;
        end
    endcase
    if (kind != 8) begin
        touched[rd[3:0]] = 1'b1;
    end
endtask

task automatic build_program();
    int         n;
    int         skip;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int i = 0; i < PROG_WORDS; i++) begin
        prog[i] = nop_instr;
    end
    prog_len = 0;
    for (int blk = 0; blk < 12; blk++) begin
        touched = '0;
        n = 3 + rnd(4);
        for (int i = 0; i < n; i++) begin
            gen_random_instr();
        end
        // Forward branch over a few instructions
        rs1  = 5'(rnd(16));
        rs2  = (rnd(3) == 0) ? rs1 : 5'(rnd(16));
        skip = 1 + rnd(3);
        emit(enc_b(13'(4 * (skip + 1)), rs2, rs1, (rnd(2) == 1) ? 3'b001 : 3'b000));
        for (int i = 0; i < skip; i++) begin
            gen_random_instr();
        end
        for (int r = 1; r < 16; r++) begin
            if (touched[r]) begin
                emit(enc_s(12'(DATA_BASE + 4 * (48 + r)), 5'(r), 5'd0));
            end
        end
    end
    emit(enc_b(13'd0, 5'd0, 5'd0, 3'b000));   // Final self-loop
endtask

// ------------------------------------------------------------
// Reference ISA model
// ------------------------------------------------------------
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic ref_run();
    logic [31:0] regs [32];
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    int          idx;
    int          steps;
    for (int r = 0; r < 32; r++) begin
        regs[r] = 32'd0;
    end
    for (int w = 0; w < DATA_WORDS; w++) begin
        ref_mem[w] = fill_word(DATA_BASE + 4 * w);
    end
    idx   = 0;
    steps = 0;
    while (idx != prog_len - 1 && steps < 20000) begin
        ins   = prog[idx];
        a     = regs[ins[19:15]];
        b     = regs[ins[24:20]];
        i_imm = {{20{ins[31]}}, ins[31:20]};
        s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        b_imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        idx++;
        case (ins[6:0])
            7'h33: regs[ins[11:7]] = ref_alu(ins[14:12], ins[30], a, b);
            7'h13: begin
                if (ins[14:12] == 3'd1 || ins[14:12] == 3'd5) begin
                    regs[ins[11:7]] = ref_alu(ins[14:12], ins[30], a, {27'd0, ins[24:20]});
                end else begin
                    regs[ins[11:7]] = ref_alu(ins[14:12], 1'b0, a, i_imm);
                end
            end
            7'h03: begin
                addr = a + i_imm;
                regs[ins[11:7]] = ref_mem[(addr - DATA_BASE) >> 2];
            end
            7'h23: begin
                addr = a + s_imm;
                ref_mem[(addr - DATA_BASE) >> 2] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            7'h63: begin
                if ((a == b) == (ins[14:12] == 3'b000)) begin
                    idx = idx - 1 + int'($signed(b_imm)) / 4;
                end
            end
            default: ;
        endcase
        regs[0] = 32'd0;
        steps++;
    end
endtask

`endif

//--- dv/cpu_tb.sv
// CPU pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam logic [31:0] RESET_PC   = 32'h0000_0100;
    localparam int          PROG_WORDS = 1024;
    localparam int          DATA_WORDS = 64;
    localparam int          DATA_BASE  = 1024;    // Byte address of data region

    logic        clk;
    logic        reset_n;
    imem_req_t   imem_req;
    logic        imem_ready;
    logic [31:0] imem_rdata;
    dmem_req_t   dmem_req;
    logic        dmem_ready;
    logic [31:0] dmem_rdata;

    logic [31:0] lcg_state;
    logic [31:0] prog [PROG_WORDS];
    int          prog_len;
    logic [15:0] touched;              // Registers written in the current block
    logic [31:0] ref_mem [DATA_WORDS];
    logic [31:0] dmem [DATA_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] fidx;
    logic [31:0] didx;

    `include "cpu_tb_model.svh"

    cpu #(
        .reset_pc (RESET_PC)
    ) cpu_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .imem_req   (imem_req),
        .imem_ready (imem_ready),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Error reporting and checks
    // ------------------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on timeout");
    endtask

    task automatic check_fetch(input imem_req_t req, input logic [31:0] addr);
        if (req.addr !== addr) begin
            stop_on_error($sformatf("fetch addr %h, expected %h", req.addr, addr));
        end
    endtask

    task automatic check_store(input dmem_req_t req, input logic [31:0] addr,
                               input logic [31:0] data);
        if (req.addr !== addr || req.wdata !== data) begin
            stop_on_error($sformatf("store %h <= %h, expected %h <= %h",
                                    req.addr, req.wdata, addr, data));
        end
    endtask

    task automatic check_held(input dmem_req_t req, input dmem_req_t prev);
        if (req !== prev) begin
            stop_on_error($sformatf("data request changed while stalled: %h -> %h",
                                    prev, req));
        end
    endtask

    // ------------------------------------------------------------
    // Memory responders
    // ------------------------------------------------------------
    // Word indexes of the current requests
    always_comb begin
        fidx = (imem_req.addr - RESET_PC) >> 2;
        didx = (dmem_req.addr - DATA_BASE) >> 2;
    end

    // Ready pulses for one cycle, only on a request held over the last edge
    initial begin
        imem_ready = 1'b0;
        imem_rdata = nop_instr;
        dmem_ready = 1'b0;
        dmem_rdata = 32'd0;
        forever begin
            @(posedge clk);
            if (!reset_n) begin
                imem_ready <= 1'b0;
                dmem_ready <= 1'b0;
            end else begin
                imem_ready <= !imem_ready && (rnd(4) != 0);
                imem_rdata <= (fidx < PROG_WORDS) ? prog[fidx[9:0]] : nop_instr;
                dmem_ready <= !dmem_ready && dmem_req.valid && (rnd(4) != 0);
                dmem_rdata <= (didx < DATA_WORDS) ? dmem[didx[5:0]] : 32'hDEAD_BEEF;
            end
        end
    end

    // Store comparison and data memory writes, mid-cycle where all is stable
    initial begin
        dmem_req_t prev_req;
        logic      held;
        held = 1'b0;
        prev_req = '0;
        for (int w = 0; w < DATA_WORDS; w++) begin
            dmem[w] = fill_word(DATA_BASE + 4 * w);
        end
        forever begin
            @(negedge clk);
            if (reset_n) begin
                if (held) begin
                    check_held(dmem_req, prev_req);
                end
                if (dmem_req.valid && didx >= DATA_WORDS) begin
                    $display("Data access at %h lies outside the data region", dmem_req.addr);
                    $display("*** TEST FAILED ***");
                    $fatal(1, "Simulation stopped on bad access");
                end
                if (dmem_req.valid && dmem_req.write && dmem_ready) begin
                    if (exp_addr.size() == 0) begin
                        stop_on_error($sformatf("unexpected store %h <= %h",
                                                dmem_req.addr, dmem_req.wdata));
                    end
                    check_store(dmem_req, exp_addr.pop_front(), exp_data.pop_front());
                    dmem[didx[5:0]] = dmem_req.wdata;
                end
                held     = dmem_req.valid && !dmem_ready;
                prev_req = dmem_req;
            end
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int          cycles;
        int          loop_hits;
        logic [31:0] loop_pc;
        reset_n   = 1'b0;
        lcg_state = 32'd81179;
        build_program();
        ref_run();
        loop_pc = RESET_PC + 32'(4 * (prog_len - 1));
        $display("Program of %0d words, %0d stores expected", prog_len, exp_addr.size());
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        cycles = 0;
        @(negedge clk);
        while (!imem_req.valid) begin
            if (cycles > 100) begin
                report_timeout("the first fetch request");
            end
            @(negedge clk);
            cycles++;
        end
        check_fetch(imem_req, RESET_PC);
        if (dmem_req.valid) begin
            stop_on_error("data request active right after reset");
        end

        // Enough loop fetches that the loop branch itself has been taken
        cycles    = 0;
        loop_hits = 0;
        while (loop_hits < 16) begin
            if (cycles > 200000) begin
                report_timeout("the final self-loop");
            end
            @(negedge clk);
            if (imem_req.valid && imem_ready && imem_req.addr == loop_pc) begin
                loop_hits++;
            end
            cycles++;
        end

        if (exp_addr.size() != 0) begin
            $display("Expected stores left over: %0d", exp_addr.size());
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation stopped with stores outstanding");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- cpu.f
+incdir+dv
rtl/cpu_pkg.sv
rtl/cpu_decoder.sv
rtl/cpu_alu.sv
rtl/cpu_regfile.sv
rtl/cpu_hazard_unit.sv
rtl/cpu.sv
dv/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
verilator --binary --timing -f cpu.f --top-module cpu_tb -Mdir obj_dir -o cpu_tb_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/cpu_tb_sim > sim.log 2>&1 || echo "Simulator returned a failing status"
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation passed"
exit 0
